// File: mem_pkg.sv
`default_nettype none

package mem_pkg;

   localparam int num_regions = 6;

   // Region order shared by CPU ports and RAM blocks
   localparam int mem_bios = 0;
   localparam int mem_ext  = 1;
   localparam int mem_dsk  = 2;
   localparam int mem_ram  = 3;
   localparam int mem_fwa  = 4;
   localparam int mem_fwb  = 5;

   localparam int addr_w      = 25;
   localparam int load_addr_w = 27;
   localparam int data_w      = 8;

   // Address bits per region, in region order
   localparam int region_addr_w [num_regions] = '{15, 14, 14, 16, 17, 16};

   // Loader index, low six bits
   localparam logic [5:0] idx_legacy = 6'd0;
   localparam logic [5:0] idx_bios   = 6'd1;
   localparam logic [5:0] idx_ext    = 6'd2;
   localparam logic [5:0] idx_dsk    = 6'd3;
   localparam logic [5:0] idx_rom_a  = 6'd6;
   localparam logic [5:0] idx_rom_b  = 6'd7;
   localparam logic [5:0] idx_fw_a   = 6'd8;
   localparam logic [5:0] idx_fw_b   = 6'd9;

   // Upper ten bits of a legacy index
   localparam logic [9:0] legacy_bios = 10'd0;
   localparam logic [9:0] legacy_ext  = 10'd1;
   localparam logic [9:0] legacy_dsk  = 10'd2;

   typedef logic [addr_w-1:0]      addr_t;
   typedef logic [data_w-1:0]      byte_t;
   typedef logic [num_regions-1:0] region_vec_t;

endpackage

`default_nettype wire

// File: load_if.sv
`timescale 1ns/1ps
`default_nettype none

// Loader write bus, one source and six region sinks
interface load_if import mem_pkg::*; ();

   region_vec_t            sel;  // At most one region
   logic [load_addr_w-1:0] addr;
   byte_t                  data;
   logic                   wr;

   modport src (
      output sel,
      output addr,
      output data,
      output wr
   );

   modport dst (
      input sel,
      input addr,
      input data,
      input wr
   );

endinterface

`default_nettype wire

// File: download_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module download_decoder import mem_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        ioctl_download,
   input  logic [15:0] ioctl_index,
   input  logic        ioctl_wr,
   input  logic [26:0] ioctl_addr,
   input  byte_t       ioctl_dout,
   input  logic [1:0]  rom_eject,
   input  logic [1:0]  cart_changed,
   input  logic [1:0]  fw_wren,
   load_if.src         load,
   output logic        reset_req,
   output logic [1:0]  cart_enable
);

   logic [5:0]  idx_type;
   logic [9:0]  idx_sub;
   region_vec_t sel;
   logic [1:0]  slot_load;
   logic [1:0]  slot_clr;
   logic [1:0]  slot_set;

   assign idx_type = ioctl_index[5:0];
   assign idx_sub  = ioctl_index[15:6];

   always_comb begin
      sel = '0;
      if (ioctl_download) begin
         case (idx_type)
            idx_bios: sel[mem_bios] = 1'b1;
            idx_ext:  sel[mem_ext]  = 1'b1;
            idx_dsk:  sel[mem_dsk]  = 1'b1;
            idx_rom_a, idx_fw_a: sel[mem_fwa] = 1'b1;  // ROM and FW share a slot
            idx_rom_b, idx_fw_b: sel[mem_fwb] = 1'b1;
            idx_legacy: begin
               case (idx_sub)
                  legacy_bios: sel[mem_bios] = 1'b1;
                  legacy_ext:  sel[mem_ext]  = 1'b1;
                  legacy_dsk:  sel[mem_dsk]  = 1'b1;
                  default: ;
               endcase
            end
            default: ;  // Unknown index loads nothing
         endcase
      end
   end

   assign load.sel  = sel;
   assign load.addr = ioctl_addr;
   assign load.data = ioctl_dout;
   assign load.wr   = ioctl_wr;

   assign reset_req = ioctl_download;

   assign slot_load = {sel[mem_fwb], sel[mem_fwa]};
   assign slot_clr  = rom_eject | cart_changed;
   assign slot_set  = slot_load | fw_wren;

   // Set beats clear in the same cycle
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cart_enable <= '0;
      end else begin
         cart_enable <= (cart_enable & ~slot_clr) | slot_set;
      end
   end

   // A loader strobe outside a download would be dropped
   a_wr_in_download: assert property (@(posedge clk) disable iff (!rst_n)
      ioctl_wr |-> ioctl_download);

endmodule

`default_nettype wire

// File: mem_region.sv
`timescale 1ns/1ps
`default_nettype none

module mem_region import mem_pkg::*; #(
   parameter int width = 14
) (
   input  logic  clk,
   input  logic  region_sel,
   load_if.dst   load,
   input  addr_t addr,
   input  byte_t data,
   input  logic  wren,
   output byte_t q,
   output logic  overflow
);

   localparam int depth = 2 ** width;

   byte_t            ram [depth];
   logic [width-1:0] ram_addr;
   byte_t            ram_wdata;
   logic             ram_we;
   logic             cpu_ovf;
   logic             load_ovf;

   assign cpu_ovf  = addr[addr_w-1:width] != '0;
   assign load_ovf = load.addr[load_addr_w-1:width] != '0;

   // Loader owns the port for the whole download
   always_comb begin
      if (region_sel) begin
         ram_addr  = load.addr[width-1:0];
         ram_wdata = load.data;
         ram_we    = load.wr && !load_ovf;
      end else begin
         ram_addr  = addr[width-1:0];
         ram_wdata = data;
         ram_we    = wren && !cpu_ovf;
      end
   end

   always_ff @(posedge clk) begin
      if (ram_we) begin
         ram[ram_addr] <= ram_wdata;
      end
      q        <= ram[ram_addr];  // Old data on a same-cycle write
      overflow <= cpu_ovf;
   end

   a_no_cpu_write_in_load: assert property (@(posedge clk) region_sel |-> !wren);

endmodule

`default_nettype wire

// File: read_gate.sv
`timescale 1ns/1ps
`default_nettype none

module read_gate import mem_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  region_vec_t mem_rden,
   input  byte_t       region_q [num_regions],
   input  region_vec_t region_overflow,
   input  logic [1:0]  cart_enable,
   output byte_t       mem_q [num_regions]
);

   region_vec_t rden_q;
   logic [1:0]  cart_q;
   region_vec_t gate_en;

   // Aligned with the one-cycle RAM read
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rden_q <= '0;
         cart_q <= '0;
      end else begin
         rden_q <= mem_rden;
         cart_q <= cart_enable;
      end
   end

   always_comb begin
      gate_en          = '1;
      gate_en[mem_fwa] = cart_q[0];
      gate_en[mem_fwb] = cart_q[1];  // Empty slot reads as open bus
   end

   for (genvar i = 0; i < num_regions; i++) begin : g_port
      assign mem_q[i] = (rden_q[i] && !region_overflow[i] && gate_en[i]) ?
                        region_q[i] : 8'hFF;

      a_q_known: assert property (@(posedge clk) disable iff (!rst_n)
         !$isunknown(mem_q[i]));
   end

endmodule

`default_nettype wire

// File: msx_memory.sv
`timescale 1ns/1ps
`default_nettype none

module msx_memory import mem_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   output logic        reset_req,
   input  logic [1:0]  cart_changed,
   input  addr_t       mem_addr [num_regions],
   input  byte_t       mem_data [num_regions],
   input  region_vec_t mem_wren,
   input  region_vec_t mem_rden,
   output byte_t       mem_q [num_regions],
   input  logic        ioctl_download,
   input  logic [15:0] ioctl_index,
   input  logic        ioctl_wr,
   input  logic [26:0] ioctl_addr,
   input  byte_t       ioctl_dout,
   input  logic [1:0]  rom_eject
);

   load_if      load_bus ();
   logic [1:0]  cart_enable;
   byte_t       region_q [num_regions];
   region_vec_t region_overflow;

   download_decoder i_download_decoder (
      .clk            (clk),
      .rst_n          (rst_n),
      .ioctl_download (ioctl_download),
      .ioctl_index    (ioctl_index),
      .ioctl_wr       (ioctl_wr),
      .ioctl_addr     (ioctl_addr),
      .ioctl_dout     (ioctl_dout),
      .rom_eject      (rom_eject),
      .cart_changed   (cart_changed),
      .fw_wren        ({mem_wren[mem_fwb], mem_wren[mem_fwa]}),
      .load           (load_bus.src),
      .reset_req      (reset_req),
      .cart_enable    (cart_enable)
   );

   for (genvar i = 0; i < num_regions; i++) begin : g_region
      mem_region #(.width(region_addr_w[i])) i_mem_region (
         .clk        (clk),
         .region_sel (load_bus.sel[i]),
         .load       (load_bus.dst),
         .addr       (mem_addr[i]),
         .data       (mem_data[i]),
         .wren       (mem_wren[i]),
         .q          (region_q[i]),
         .overflow   (region_overflow[i])
      );
   end

   read_gate i_read_gate (
      .clk             (clk),
      .rst_n           (rst_n),
      .mem_rden        (mem_rden),
      .region_q        (region_q),
      .region_overflow (region_overflow),
      .cart_enable     (cart_enable),
      .mem_q           (mem_q)
   );

endmodule

`default_nettype wire

// File: tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker import mem_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  addr_t       mem_addr [num_regions],
   input  byte_t       mem_data [num_regions],
   input  region_vec_t mem_wren,
   input  region_vec_t mem_rden,
   input  byte_t       mem_q [num_regions],
   input  logic        reset_req,
   input  logic        ioctl_download,
   input  logic [15:0] ioctl_index,
   input  logic        ioctl_wr,
   input  logic [26:0] ioctl_addr,
   input  byte_t       ioctl_dout,
   input  logic [1:0]  rom_eject,
   input  logic [1:0]  cart_changed,
   output int          read_errors,
   output int          req_errors,
   output int          checks
);

   string      test_name = "reset";
   byte_t      model [int];  // Bytes written so far, keyed by region and address
   logic [1:0] cart;
   byte_t      exp_q [num_regions];
   bit         exp_known [num_regions];

   // Region hit by the loader, or -1
   function automatic int load_target(input logic dl, input logic [15:0] index);
      int r;
      r = -1;
      if (dl) begin
         case (index[5:0])
            idx_bios:            r = mem_bios;
            idx_ext:             r = mem_ext;
            idx_dsk:             r = mem_dsk;
            idx_rom_a, idx_fw_a: r = mem_fwa;
            idx_rom_b, idx_fw_b: r = mem_fwb;
            idx_legacy: begin
               if (index[15:6] == 10'd0) r = mem_bios;
               else if (index[15:6] == 10'd1) r = mem_ext;
               else if (index[15:6] == 10'd2) r = mem_dsk;
            end
            default: r = -1;
         endcase
      end
      return r;
   endfunction

   function automatic bit in_range(input int r, input logic [26:0] a);
      return (a >> region_addr_w[r]) == 27'd0;
   endfunction

   function automatic int model_key(input int r, input logic [26:0] a);
      return (r << 17) | int'(a[16:0]);
   endfunction

   // Returns 0 when the byte was never written
   function automatic bit expected_q(input int r, input addr_t a, input logic cart_en,
                                     input logic rd, output byte_t value);
      int key;
      value = 8'hFF;
      key = model_key(r, {2'b00, a});
      if (!rd || !in_range(r, {2'b00, a})) return 1'b1;
      if ((r == mem_fwa || r == mem_fwb) && !cart_en) return 1'b1;
      if (!model.exists(key)) return 1'b0;
      value = model[key];
      return 1'b1;
   endfunction

   always @(posedge clk) begin
      int         ld;
      logic       cart_en;
      logic [1:0] slot_set;
      if (!rst_n) begin
         cart = 2'b00;
         req_errors = 0;
         for (int i = 0; i < num_regions; i++) exp_known[i] = 1'b0;
      end else begin
         ld = load_target(ioctl_download, ioctl_index);
         if (reset_req !== ioctl_download) begin
            req_errors++;
            $display("ERROR %0s reset_req: expected %0b, actual %0b",
                     test_name, ioctl_download, reset_req);
         end
         // Expectations use memory contents before this edge's writes
         for (int i = 0; i < num_regions; i++) begin
            cart_en = (i == mem_fwa) ? cart[0] : ((i == mem_fwb) ? cart[1] : 1'b1);
            exp_known[i] = expected_q(i, mem_addr[i], cart_en, mem_rden[i], exp_q[i]);
            if (i == ld && mem_rden[i]) exp_known[i] = 1'b0;  // Loader owns the address
         end
         if (ld >= 0 && ioctl_wr) begin
            if (in_range(ld, ioctl_addr)) model[model_key(ld, ioctl_addr)] = ioctl_dout;
         end
         for (int i = 0; i < num_regions; i++) begin
            if (mem_wren[i] && i != ld && in_range(i, {2'b00, mem_addr[i]})) begin
               model[model_key(i, {2'b00, mem_addr[i]})] = mem_data[i];
            end
         end
         slot_set[0] = (ld == mem_fwa) || mem_wren[mem_fwa];
         slot_set[1] = (ld == mem_fwb) || mem_wren[mem_fwb];
         cart = (cart & ~(rom_eject | cart_changed)) | slot_set;
      end
   end

   // Read data is stable half a cycle after the capturing edge
   always @(negedge clk) begin
      if (!rst_n) begin
         read_errors = 0;
         checks = 0;
      end else begin
         for (int i = 0; i < num_regions; i++) begin
            if (exp_known[i]) begin
               checks++;
               if (mem_q[i] !== exp_q[i]) begin
                  read_errors++;
                  $display("ERROR %0s port %0d: expected %02h, actual %02h",
                           test_name, i, exp_q[i], mem_q[i]);
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: tb_msx_memory.sv
`timescale 1ns/1ps
`default_nettype none

module tb_msx_memory import mem_pkg::*; ();

   localparam int period       = 100;
   localparam int reset_cycles = 10;
   localparam int fill_len     = 48;
   localparam int ram_ops      = 160;
   localparam int test_cycles  = reset_cycles + 6 * (2 * fill_len + 4) + 2 * ram_ops + 300;

   logic        clk = 1'b0;
   logic        rst_n;
   logic        reset_req;
   logic [1:0]  cart_changed;
   addr_t       mem_addr [num_regions];
   byte_t       mem_data [num_regions];
   region_vec_t mem_wren;
   region_vec_t mem_rden;
   byte_t       mem_q [num_regions];
   logic        ioctl_download;
   logic [15:0] ioctl_index;
   logic        ioctl_wr;
   logic [26:0] ioctl_addr;
   byte_t       ioctl_dout;
   logic [1:0]  rom_eject;
   logic [31:0] rng_state;
   int          read_errors;
   int          req_errors;
   int          checks;

   msx_memory i_msx_memory (
      .clk            (clk),
      .rst_n          (rst_n),
      .reset_req      (reset_req),
      .cart_changed   (cart_changed),
      .mem_addr       (mem_addr),
      .mem_data       (mem_data),
      .mem_wren       (mem_wren),
      .mem_rden       (mem_rden),
      .mem_q          (mem_q),
      .ioctl_download (ioctl_download),
      .ioctl_index    (ioctl_index),
      .ioctl_wr       (ioctl_wr),
      .ioctl_addr     (ioctl_addr),
      .ioctl_dout     (ioctl_dout),
      .rom_eject      (rom_eject)
   );

   tb_checker i_tb_checker (
      .clk            (clk),
      .rst_n          (rst_n),
      .mem_addr       (mem_addr),
      .mem_data       (mem_data),
      .mem_wren       (mem_wren),
      .mem_rden       (mem_rden),
      .mem_q          (mem_q),
      .reset_req      (reset_req),
      .ioctl_download (ioctl_download),
      .ioctl_index    (ioctl_index),
      .ioctl_wr       (ioctl_wr),
      .ioctl_addr     (ioctl_addr),
      .ioctl_dout     (ioctl_dout),
      .rom_eject      (rom_eject),
      .cart_changed   (cart_changed),
      .read_errors    (read_errors),
      .req_errors     (req_errors),
      .checks         (checks)
   );

   always #(period / 2) clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic draw(output logic [31:0] r);
      rng_state = xorshift(rng_state);
      r = rng_state;
   endtask

   // Random bytes to consecutive loader addresses
   task automatic download(input logic [15:0] index, input int base, input int count);
      logic [31:0] r;
      @(negedge clk);
      ioctl_download = 1'b1;
      ioctl_index = index;
      for (int k = 0; k < count; k++) begin
         @(negedge clk);
         draw(r);
         ioctl_wr = 1'b1;
         ioctl_addr = 27'(base + k);
         ioctl_dout = r[7:0];
      end
      @(negedge clk);
      ioctl_wr = 1'b0;
      @(negedge clk);
      ioctl_download = 1'b0;
   endtask

   task automatic read_range(input int port, input int base, input int count);
      for (int k = 0; k < count; k++) begin
         @(negedge clk);
         mem_rden[port] = 1'b1;  // Back to back reads
         mem_addr[port] = addr_t'(base + k);
      end
      @(negedge clk);
      mem_rden[port] = 1'b0;
   endtask

   task automatic cpu_write(input int port, input int addr, input byte_t data);
      @(negedge clk);
      mem_wren[port] = 1'b1;
      mem_addr[port] = addr_t'(addr);
      mem_data[port] = data;
      @(negedge clk);
      mem_wren[port] = 1'b0;
   endtask

   task automatic slot_event(input logic [1:0] eject, input logic [1:0] changed);
      @(negedge clk);
      rom_eject = eject;
      cart_changed = changed;
      @(negedge clk);
      rom_eject = 2'b00;
      cart_changed = 2'b00;
   endtask

   initial begin
      #(2 * test_cycles * period);
      $display("Timeout: run did not finish within %0d clock cycles", 2 * test_cycles);
      $display("Checks failed");
      $finish;
   end

   initial begin
      logic [31:0] r;
      int          a;
      rng_state = 32'h1b86_20aa;
      rst_n = 1'b0;
      cart_changed = 2'b00;
      rom_eject = 2'b00;
      mem_wren = '0;
      mem_rden = '0;
      ioctl_download = 1'b0;
      ioctl_index = 16'd0;
      ioctl_wr = 1'b0;
      ioctl_addr = 27'd0;
      ioctl_dout = 8'h00;
      for (int i = 0; i < num_regions; i++) begin
         mem_addr[i] = '0;
         mem_data[i] = '0;
      end
      repeat (reset_cycles) @(negedge clk);
      rst_n = 1'b1;

      i_tb_checker.test_name = "fw_after_reset";
      read_range(mem_fwa, 0, 4);
      read_range(mem_fwb, 0, 4);

      i_tb_checker.test_name = "rom_fill";
      download({10'd0, idx_bios}, 0, fill_len);
      read_range(mem_bios, 0, fill_len);
      download({10'd0, idx_ext}, 0, fill_len);
      read_range(mem_ext, 0, fill_len);
      download({10'd0, idx_dsk}, 0, fill_len);
      read_range(mem_dsk, 0, fill_len);
      download({legacy_bios, idx_legacy}, 0, fill_len);
      read_range(mem_bios, 0, fill_len);
      download({legacy_ext, idx_legacy}, 0, fill_len);
      read_range(mem_ext, 0, fill_len);
      download({legacy_dsk, idx_legacy}, 0, fill_len);
      read_range(mem_dsk, 0, fill_len);

      i_tb_checker.test_name = "ram_random";
      for (int n = 0; n < ram_ops; n++) begin
         draw(r);
         a = int'({r[15:13], 10'd0, r[2:0]});  // 64 spread addresses
         if (r[16]) cpu_write(mem_ram, a, r[31:24]);
         else read_range(mem_ram, a, 1);
      end

      i_tb_checker.test_name = "out_of_range";
      download({10'd0, idx_bios}, 1 << 15, 8);
      read_range(mem_bios, 0, 8);
      download({10'd0, idx_ext}, 1 << 14, 8);
      read_range(mem_ext, 0, 8);
      read_range(mem_dsk, 1 << 14, 4);
      read_range(mem_ram, (1 << 16) + 5, 4);

      i_tb_checker.test_name = "cart_enable";
      download({10'd0, idx_rom_a}, 0, 16);
      read_range(mem_fwa, 0, 16);
      read_range(mem_fwb, 0, 4);
      download({10'd0, idx_fw_b}, 0, 16);
      read_range(mem_fwb, 0, 16);
      slot_event(2'b01, 2'b00);
      read_range(mem_fwa, 0, 4);
      slot_event(2'b00, 2'b10);
      read_range(mem_fwb, 0, 4);
      cpu_write(mem_fwb, 3, 8'h5a);
      read_range(mem_fwb, 0, 16);

      i_tb_checker.test_name = "idle_and_reset_req";
      for (int i = 0; i < num_regions; i++) mem_addr[i] = addr_t'(2);
      repeat (4) @(negedge clk);
      download(16'd12, 0, 4);  // Unknown index writes nothing
      read_range(mem_bios, 0, 4);
      repeat (4) @(negedge clk);

      $display("Checks: %0d, read errors: %0d, reset_req errors: %0d",
               checks, read_errors, req_errors);
      if (read_errors == 0 && req_errors == 0 && checks > 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sim.f
mem_pkg.sv
load_if.sv
download_decoder.sv
mem_region.sv
read_gate.sv
msx_memory.sv
tb_checker.sv
tb_msx_memory.sv

// File: run.sh
#!/bin/sh
# Build and run the msx_memory testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_msx_memory

out=$(./obj_dir/Vtb_msx_memory)
echo "$out"

if echo "$out" | grep -qx "All checks passed"; then
   exit 0
else
   exit 1
fi
